//--- rtl/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// first address fetched once reset is released
`define FETCH_RESET_VECTOR 32'h0000_0100

// direct-mapped, one 32-bit word per line
`define FETCH_CACHE_LINES 16

// instruction ROM size in words
// byte addresses at or above FETCH_ROM_WORDS * 4 fault
`define FETCH_ROM_WORDS 1024

// cycles from rom_req to rom_valid
`define FETCH_ROM_LATENCY 3

// addi x0, x0, 0
`define FETCH_NOP 32'h0000_0013

`endif

//--- rtl/fetch_pkg.sv
package fetch_pkg;

    typedef enum logic [1:0] {
        CMD_NONE      = 2'd0,
        CMD_EXECUTE   = 2'd1,
        CMD_FLUSH_ALL = 2'd2
    } cache_cmd_e;

    typedef enum logic [2:0] {
        RSP_IDLE         = 3'd0,
        RSP_WAIT         = 3'd1,
        RSP_DONE         = 3'd2,
        RSP_MISALIGNED   = 3'd3,
        RSP_ACCESS_FAULT = 3'd4
    } cache_resp_e;

    // low bits of mcause
    typedef enum logic [3:0] {
        EXC_ADDR_MISALIGNED = 4'd0,
        EXC_ACCESS_FAULT    = 4'd1,
        EXC_TIMER_IRQ       = 4'd7,
        EXC_EXTERNAL_IRQ    = 4'd11
    } exc_code_e;

    typedef enum logic [1:0] {
        FS_RESET,
        FS_RUN,
        FS_FLUSH,
        FS_AFTER_FLUSH
    } fetch_state_e;

    typedef enum logic [1:0] {
        CS_IDLE,
        CS_REFILL,
        CS_FLUSH
    } cache_state_e;

    typedef struct packed {
        cache_cmd_e  cmd;
        logic [31:0] addr;
    } cache_req_t;

    typedef struct packed {
        cache_resp_e resp;
        logic [31:0] data;
    } cache_rsp_t;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic        exc_start;
        exc_code_e   cause;
        logic        interrupt;
    } f2e_t;

    typedef struct packed {
        logic        ready;
        logic        exc_start;
        logic        exc_return;
        logic [31:0] epc;
        logic        flush;
        logic        branch_taken;
        logic [31:0] branch_target;
    } e2f_t;

endpackage

//--- rtl/fetch_ctrl.sv
`timescale 1ns/1ns
`include "fetch_defines.svh"

module fetch_ctrl (
    input  logic                  clk,
    input  logic                  reseted,
    input  logic [31:0]           mtvec,
    input  logic                  irq_timer,
    input  logic                  irq_external,
    input  fetch_pkg::e2f_t       e2f,
    output fetch_pkg::f2e_t       f2e,
    output fetch_pkg::cache_req_t cache_req,
    input  fetch_pkg::cache_rsp_t cache_rsp
);

    fetch_pkg::fetch_state_e state;
    fetch_pkg::fetch_state_e state_next;
    fetch_pkg::cache_cmd_e   cmd;
    fetch_pkg::exc_code_e    cause;
    logic [31:0]             pc;
    logic [31:0]             next_pc;
    logic [31:0]             saved_instr;
    logic [31:0]             instr;
    logic                    exc_start;
    logic                    cause_irq;
    logic                    rsp_done;
    logic                    rsp_idle;
    logic                    rsp_wait;
    logic                    rsp_misaligned;
    logic                    rsp_access_fault;
    logic                    rsp_fault;
    logic                    accept;

    assign rsp_done         = cache_rsp.resp == fetch_pkg::RSP_DONE;
    assign rsp_idle         = cache_rsp.resp == fetch_pkg::RSP_IDLE;
    assign rsp_wait         = cache_rsp.resp == fetch_pkg::RSP_WAIT;
    assign rsp_misaligned   = cache_rsp.resp == fetch_pkg::RSP_MISALIGNED;
    assign rsp_access_fault = cache_rsp.resp == fetch_pkg::RSP_ACCESS_FAULT;
    assign rsp_fault        = rsp_misaligned || rsp_access_fault;

    // cycles where a new fetch address may be chosen, none while reset is held
    assign accept = !reseted && (state != fetch_pkg::FS_FLUSH) && !rsp_wait &&
                    ((state == fetch_pkg::FS_RESET) || rsp_fault ||
                     (e2f.ready && (rsp_done || rsp_idle)));

    // instruction towards execute
    always_comb begin
        instr = `FETCH_NOP;
        if (state != fetch_pkg::FS_RESET && state != fetch_pkg::FS_FLUSH) begin
            if (rsp_done) begin
                instr = cache_rsp.data;
            end else if (rsp_idle && state != fetch_pkg::FS_AFTER_FLUSH) begin
                // execute stalled, keep presenting the same word
                instr = saved_instr;
            end
        end
    end

    // fault codes beat interrupts, external beats timer
    always_comb begin
        cause     = fetch_pkg::EXC_ADDR_MISALIGNED;
        cause_irq = 1'b0;
        if (rsp_misaligned) begin
            cause = fetch_pkg::EXC_ADDR_MISALIGNED;
        end else if (rsp_access_fault) begin
            cause = fetch_pkg::EXC_ACCESS_FAULT;
        end else if (irq_external) begin
            cause     = fetch_pkg::EXC_EXTERNAL_IRQ;
            cause_irq = 1'b1;
        end else if (irq_timer) begin
            cause     = fetch_pkg::EXC_TIMER_IRQ;
            cause_irq = 1'b1;
        end
    end

    // next address and cache command
    always_comb begin
        next_pc    = pc;
        cmd        = fetch_pkg::CMD_NONE;
        exc_start  = 1'b0;
        state_next = state;
        if (state == fetch_pkg::FS_FLUSH) begin
            if (!rsp_done) begin
                cmd = fetch_pkg::CMD_FLUSH_ALL;
            end else begin
                state_next = fetch_pkg::FS_AFTER_FLUSH;
            end
        end else if (rsp_wait) begin
            // refill or fault check still running, hold the request
            cmd = fetch_pkg::CMD_EXECUTE;
        end else if (accept) begin
            cmd        = fetch_pkg::CMD_EXECUTE;
            state_next = fetch_pkg::FS_RUN;
            if (state == fetch_pkg::FS_RESET) begin
                next_pc = `FETCH_RESET_VECTOR;
            end else if (irq_external || irq_timer) begin
                exc_start = 1'b1;
                next_pc   = mtvec;
            end else if (e2f.exc_return) begin
                next_pc = e2f.epc;
            end else if (e2f.branch_taken) begin
                next_pc = e2f.branch_target;
            end else if (e2f.ready && e2f.flush) begin
                // pc stays put so fetching resumes at pc + 4
                cmd        = fetch_pkg::CMD_FLUSH_ALL;
                state_next = fetch_pkg::FS_FLUSH;
            end else if (e2f.ready && e2f.exc_start) begin
                next_pc = mtvec;
            end else if (rsp_fault) begin
                exc_start = 1'b1;
                next_pc   = mtvec;
            end else begin
                next_pc = pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reseted) begin
            state <= fetch_pkg::FS_RESET;
            pc    <= `FETCH_RESET_VECTOR;
        end else begin
            state <= state_next;
            pc    <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        saved_instr <= instr;
    end

    assign cache_req.cmd  = cmd;
    assign cache_req.addr = next_pc;

    assign f2e.instr     = instr;
    assign f2e.pc        = pc;
    assign f2e.exc_start = exc_start;
    assign f2e.cause     = cause;
    assign f2e.interrupt = cause_irq;

endmodule

//--- rtl/icache.sv
`timescale 1ns/1ns
`include "fetch_defines.svh"

module icache (
    input  logic                  clk,
    input  logic                  reseted,
    input  fetch_pkg::cache_req_t cache_req,
    output fetch_pkg::cache_rsp_t cache_rsp,
    output logic                  rom_req,
    output logic [31:0]           rom_addr,
    input  logic                  rom_valid,
    input  logic [31:0]           rom_data
);

    localparam int          LINES     = `FETCH_CACHE_LINES;
    localparam int          IDX_W     = $clog2(LINES);
    localparam int          TAG_W     = 30 - IDX_W;
    localparam logic [31:0] ROM_BYTES = 32'(`FETCH_ROM_WORDS * 4);

    fetch_pkg::cache_state_e state;
    fetch_pkg::cache_resp_e  rsp_resp;
    logic [31:0]             rsp_data;
    logic [LINES-1:0]        valid;
    logic [TAG_W-1:0]        tag_mem [LINES];
    logic [31:0]             data_mem [LINES];
    logic [IDX_W-1:0]        flush_idx;
    logic [IDX_W-1:0]        req_idx;
    logic [TAG_W-1:0]        req_tag;
    logic [IDX_W-1:0]        refill_idx;
    logic                    misaligned;
    logic                    out_of_range;
    logic                    hit;
    logic                    lookup;

    assign req_idx    = cache_req.addr[2 +: IDX_W];
    assign req_tag    = cache_req.addr[31 -: TAG_W];
    assign refill_idx = rom_addr[2 +: IDX_W];

    // fault checks come before the tag lookup
    assign misaligned   = cache_req.addr[1:0] != 2'b00;
    assign out_of_range = cache_req.addr >= ROM_BYTES;
    assign hit          = valid[req_idx] && (tag_mem[req_idx] == req_tag);
    assign lookup       = (state == fetch_pkg::CS_IDLE) &&
                          (cache_req.cmd == fetch_pkg::CMD_EXECUTE);

    always_ff @(posedge clk) begin
        if (reseted) begin
            state     <= fetch_pkg::CS_IDLE;
            rsp_resp  <= fetch_pkg::RSP_IDLE;
            rom_req   <= 1'b0;
            flush_idx <= '0;
            valid     <= '0;
        end else begin
            rom_req <= 1'b0;
            case (state)
                fetch_pkg::CS_IDLE: begin
                    if (cache_req.cmd == fetch_pkg::CMD_EXECUTE) begin
                        if (misaligned) begin
                            rsp_resp <= fetch_pkg::RSP_MISALIGNED;
                        end else if (out_of_range) begin
                            rsp_resp <= fetch_pkg::RSP_ACCESS_FAULT;
                        end else if (hit) begin
                            rsp_resp <= fetch_pkg::RSP_DONE;
                        end else begin
                            rsp_resp <= fetch_pkg::RSP_WAIT;
                            rom_req  <= 1'b1;
                            state    <= fetch_pkg::CS_REFILL;
                        end
                    end else if (cache_req.cmd == fetch_pkg::CMD_FLUSH_ALL) begin
                        rsp_resp  <= fetch_pkg::RSP_WAIT;
                        flush_idx <= '0;
                        state     <= fetch_pkg::CS_FLUSH;
                    end else begin
                        rsp_resp <= fetch_pkg::RSP_IDLE;
                    end
                end
                fetch_pkg::CS_REFILL: begin
                    if (rom_valid) begin
                        valid[refill_idx] <= 1'b1;
                        rsp_resp          <= fetch_pkg::RSP_DONE;
                        state             <= fetch_pkg::CS_IDLE;
                    end
                end
                default: begin
                    // one line per cycle
                    valid[flush_idx] <= 1'b0;
                    if (flush_idx == IDX_W'(LINES - 1)) begin
                        rsp_resp <= fetch_pkg::RSP_DONE;
                        state    <= fetch_pkg::CS_IDLE;
                    end else begin
                        flush_idx <= flush_idx + 1'b1;
                    end
                end
            endcase
        end
    end

    // line storage, refill address and read data
    always_ff @(posedge clk) begin
        if (lookup) begin
            rom_addr <= cache_req.addr;
            rsp_data <= data_mem[req_idx];
        end
        if (state == fetch_pkg::CS_REFILL && rom_valid) begin
            data_mem[refill_idx] <= rom_data;
            tag_mem[refill_idx]  <= rom_addr[31 -: TAG_W];
            rsp_data             <= rom_data;
        end
    end

    assign cache_rsp.resp = rsp_resp;
    assign cache_rsp.data = rsp_data;

endmodule

//--- rtl/imem_rom.sv
`timescale 1ns/1ns
`include "fetch_defines.svh"

module imem_rom (
    input  logic        clk,
    input  logic        reseted,
    input  logic        rom_req,
    input  logic [31:0] rom_addr,
    output logic        rom_valid,
    output logic [31:0] rom_data
);

    localparam int          LAT      = `FETCH_ROM_LATENCY;
    localparam int          IDX_W    = $clog2(`FETCH_ROM_WORDS);
    localparam logic [31:0] NOP_WORD = `FETCH_NOP;

    logic [LAT-1:0]   valid_pipe;
    logic [IDX_W-1:0] idx_pipe [LAT];

    always_ff @(posedge clk) begin
        if (reseted) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= rom_req;
            for (int i = 1; i < LAT; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    // only the word index travels down the line
    always_ff @(posedge clk) begin
        idx_pipe[0] <= rom_addr[2 +: IDX_W];
        for (int i = 1; i < LAT; i++) begin
            idx_pipe[i] <= idx_pipe[i-1];
        end
    end

    assign rom_valid = valid_pipe[LAT-1];
    // word index in the upper half, low half of the nop below it
    assign rom_data  = {16'(idx_pipe[LAT-1]), NOP_WORD[15:0]};

endmodule

//--- rtl/fetch_top.sv
`timescale 1ns/1ns

module fetch_top (
    input  logic              clk,
    input  logic              reseted,
    input  logic [31:0]       mtvec,
    input  logic              irq_timer,
    input  logic              irq_external,
    input  fetch_pkg::e2f_t   e2f,
    output fetch_pkg::f2e_t   f2e
);

    fetch_pkg::cache_req_t cache_req;
    fetch_pkg::cache_rsp_t cache_rsp;
    logic                  rom_req;
    logic [31:0]           rom_addr;
    logic                  rom_valid;
    logic [31:0]           rom_data;

    fetch_ctrl u_fetch_ctrl (
        .clk          (clk),
        .reseted      (reseted),
        .mtvec        (mtvec),
        .irq_timer    (irq_timer),
        .irq_external (irq_external),
        .e2f          (e2f),
        .f2e          (f2e),
        .cache_req    (cache_req),
        .cache_rsp    (cache_rsp)
    );

    icache u_icache (
        .clk       (clk),
        .reseted   (reseted),
        .cache_req (cache_req),
        .cache_rsp (cache_rsp),
        .rom_req   (rom_req),
        .rom_addr  (rom_addr),
        .rom_valid (rom_valid),
        .rom_data  (rom_data)
    );

    imem_rom u_imem_rom (
        .clk       (clk),
        .reseted   (reseted),
        .rom_req   (rom_req),
        .rom_addr  (rom_addr),
        .rom_valid (rom_valid),
        .rom_data  (rom_data)
    );

endmodule

//--- tb/tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen (
    output logic clk
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

endmodule

//--- tb/fetch_assert.sv
`timescale 1ns/1ns
`include "fetch_defines.svh"

module fetch_assert (
    input logic                  clk,
    input logic                  reseted,
    input fetch_pkg::cache_req_t cache_req,
    input fetch_pkg::cache_rsp_t cache_rsp,
    input logic                  rom_req,
    input logic                  rom_valid
);

    localparam int LAT = `FETCH_ROM_LATENCY;

    logic pending;

    // one refill in flight between rom_req and rom_valid
    always_ff @(posedge clk) begin
        if (reseted) begin
            pending <= 1'b0;
        end else if (rom_req) begin
            pending <= 1'b1;
        end else if (rom_valid) begin
            pending <= 1'b0;
        end
    end

    idle_after_reset: assert property (@(posedge clk)
        reseted |=> (!rom_req && $past(cache_req.cmd) == fetch_pkg::CMD_NONE))
        else $error("cache command issued or rom_req high around reset");

    rom_latency: assert property (@(posedge clk) disable iff (reseted)
        rom_valid == $past(rom_req, LAT))
        else $error("rom_valid does not follow rom_req by the ROM latency");

    single_request: assert property (@(posedge clk) disable iff (reseted)
        rom_req |-> !pending)
        else $error("new ROM request raised while one is pending");

endmodule

bind icache fetch_assert u_fetch_assert (
    .clk       (clk),
    .reseted   (reseted),
    .cache_req (cache_req),
    .cache_rsp (cache_rsp),
    .rom_req   (rom_req),
    .rom_valid (rom_valid)
);

//--- tb/fetch_tb.sv
`timescale 1ns/1ns
`include "fetch_defines.svh"

module fetch_tb;

    typedef enum logic [2:0] {
        EV_NONE, EV_BRANCH, EV_EXC_RETURN, EV_IRQ_TIMER,
        EV_IRQ_EXTERNAL, EV_BOTH_IRQS, EV_FLUSH, EV_EXE_EXC
    } event_e;

    typedef struct packed {
        event_e               kind;
        logic [31:0]          target;
        logic [31:0]          exp_pc;
        logic                 exc;
        fetch_pkg::exc_code_e cause;
        logic                 irq;
    } row_t;

    localparam logic [31:0] MTVEC     = 32'h0000_0200;
    localparam logic [31:0] ROM_BYTES = 32'(`FETCH_ROM_WORDS * 4);
    localparam logic [31:0] NOP_WORD  = `FETCH_NOP;
    localparam fetch_pkg::exc_code_e X_MIS = fetch_pkg::EXC_ADDR_MISALIGNED;
    localparam fetch_pkg::exc_code_e X_ACC = fetch_pkg::EXC_ACCESS_FAULT;
    localparam fetch_pkg::exc_code_e X_TMR = fetch_pkg::EXC_TIMER_IRQ;
    localparam fetch_pkg::exc_code_e X_EXT = fetch_pkg::EXC_EXTERNAL_IRQ;

    logic                 clk;
    logic                 reseted;
    logic                 irq_timer;
    logic                 irq_external;
    fetch_pkg::e2f_t      e2f;
    fetch_pkg::f2e_t      f2e;
    string                names[$];
    row_t                 rows[$];
    int                   errors;
    int                   checks;
    int                   cycles;
    int                   limit;
    int                   idx;
    logic [31:0]          model_pc;
    logic                 seen_exc;
    fetch_pkg::exc_code_e seen_cause;
    logic                 seen_irq;
    logic                 delivered;

    tb_clkgen u_clkgen (
        .clk (clk)
    );

    fetch_top uut (
        .clk          (clk),
        .reseted      (reseted),
        .mtvec        (MTVEC),
        .irq_timer    (irq_timer),
        .irq_external (irq_external),
        .e2f          (e2f),
        .f2e          (f2e)
    );

    task automatic add_row(input string name, input event_e kind, input logic [31:0] target,
                           input logic [31:0] exp_pc, input logic exc,
                           input fetch_pkg::exc_code_e cause, input logic irq);
        names.push_back(name);
        rows.push_back(row_t'{kind, target, exp_pc, exc, cause, irq});
    endtask

    // each row's event is applied when the previous instruction is delivered
    task automatic load_table();
        add_row("seq_0",              EV_NONE,         32'h0,    32'h104, 1'b0, X_MIS, 1'b0);
        add_row("seq_1",              EV_NONE,         32'h0,    32'h108, 1'b0, X_MIS, 1'b0);
        add_row("branch_back",        EV_BRANCH,       32'h100,  32'h100, 1'b0, X_MIS, 1'b0);
        add_row("hit_0",              EV_NONE,         32'h0,    32'h104, 1'b0, X_MIS, 1'b0);
        add_row("hit_1",              EV_NONE,         32'h0,    32'h108, 1'b0, X_MIS, 1'b0);
        add_row("branch_fwd",         EV_BRANCH,       32'h180,  32'h180, 1'b0, X_MIS, 1'b0);
        add_row("exc_return",         EV_EXC_RETURN,   32'h140,  32'h140, 1'b0, X_MIS, 1'b0);
        add_row("irq_timer",          EV_IRQ_TIMER,    32'h0,    MTVEC,   1'b1, X_TMR, 1'b1);
        add_row("after_irq",          EV_NONE,         32'h0,    32'h204, 1'b0, X_MIS, 1'b0);
        add_row("irq_external",       EV_IRQ_EXTERNAL, 32'h0,    MTVEC,   1'b1, X_EXT, 1'b1);
        add_row("both_irqs",          EV_BOTH_IRQS,    32'h0,    MTVEC,   1'b1, X_EXT, 1'b1);
        add_row("branch_misaligned",  EV_BRANCH,       32'h102,  MTVEC,   1'b1, X_MIS, 1'b0);
        add_row("branch_past_rom",    EV_BRANCH,       32'h1000, MTVEC,   1'b1, X_ACC, 1'b0);
        add_row("flush",              EV_FLUSH,        32'h0,    32'h204, 1'b0, X_MIS, 1'b0);
        add_row("after_flush",        EV_NONE,         32'h0,    32'h208, 1'b0, X_MIS, 1'b0);
        add_row("refill_after_flush", EV_BRANCH,       32'h100,  32'h100, 1'b0, X_MIS, 1'b0);
        add_row("exe_exc",            EV_EXE_EXC,      32'h0,    MTVEC,   1'b0, X_MIS, 1'b0);
        add_row("after_exe_exc",      EV_NONE,         32'h0,    32'h204, 1'b0, X_MIS, 1'b0);
    endtask

    // word index above, low half of a nop below
    function automatic logic [31:0] rom_word(input logic [31:0] addr);
        return {addr[17:2], 16'h0013};
    endfunction

    function automatic logic [31:0] model_next_pc(input row_t r, input logic [31:0] pc);
        logic [31:0] dest;
        case (r.kind)
            EV_BRANCH, EV_EXC_RETURN: dest = r.target;
            EV_IRQ_TIMER, EV_IRQ_EXTERNAL, EV_BOTH_IRQS, EV_EXE_EXC: dest = MTVEC;
            default: dest = pc + 32'd4;
        endcase
        // a fetch that faults traps to mtvec
        if (dest[1:0] != 2'b00 || dest >= ROM_BYTES) begin
            dest = MTVEC;
        end
        return dest;
    endfunction

    task automatic drive_idle();
        e2f          = '0;
        e2f.ready    = 1'b1;
        irq_timer    = 1'b0;
        irq_external = 1'b0;
    endtask

    task automatic apply_event(input row_t r);
        case (r.kind)
            EV_BRANCH: begin
                e2f.branch_taken  = 1'b1;
                e2f.branch_target = r.target;
            end
            EV_EXC_RETURN: begin
                // a competing branch, the return must win
                e2f.exc_return    = 1'b1;
                e2f.epc           = r.target;
                e2f.branch_taken  = 1'b1;
                e2f.branch_target = r.target ^ 32'h40;
            end
            EV_IRQ_TIMER:    irq_timer = 1'b1;
            EV_IRQ_EXTERNAL: irq_external = 1'b1;
            EV_BOTH_IRQS: begin
                irq_timer    = 1'b1;
                irq_external = 1'b1;
            end
            EV_FLUSH:   e2f.flush = 1'b1;
            EV_EXE_EXC: e2f.exc_start = 1'b1;
            default: ;
        endcase
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        errors++;
        $display("** Error %s: %s expected %0h, got %0h", name, what, expected, actual);
    endtask

    // row whose instruction is awaited
    function automatic string row_name();
        if (idx >= 0) begin
            return names[idx];
        end
        return "reset_vector";
    endfunction

    task automatic check_delivery();
        string       name;
        logic [31:0] exp_pc;
        name   = row_name();
        exp_pc = `FETCH_RESET_VECTOR;
        if (idx >= 0) begin
            exp_pc = rows[idx].exp_pc;
        end
        checks++;
        if (f2e.pc !== exp_pc) begin
            report_mismatch(name, "pc", exp_pc, f2e.pc);
        end
        if (f2e.instr !== rom_word(model_pc)) begin
            report_mismatch(name, "instr", rom_word(model_pc), f2e.instr);
        end
        if (idx >= 0) begin
            if (seen_exc !== rows[idx].exc) begin
                report_mismatch(name, "exc_start", 32'(rows[idx].exc), 32'(seen_exc));
            end
            if (rows[idx].exc && seen_cause !== rows[idx].cause) begin
                report_mismatch(name, "cause", 32'(rows[idx].cause), 32'(seen_cause));
            end
            if (rows[idx].exc && seen_irq !== rows[idx].irq) begin
                report_mismatch(name, "interrupt", 32'(rows[idx].irq), 32'(seen_irq));
            end
        end
    endtask

    initial begin
        reseted    = 1'b1;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        idx        = -1;
        model_pc   = `FETCH_RESET_VECTOR;
        seen_exc   = 1'b0;
        seen_cause = X_MIS;
        seen_irq   = 1'b0;
        drive_idle();
        load_table();
        limit = rows.size() * (`FETCH_CACHE_LINES + `FETCH_ROM_LATENCY + 8) + 200;
        repeat (10) @(posedge clk);
        #1 reseted = 1'b0;
        while (idx < rows.size() && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
            drive_idle();
            delivered = (uut.cache_rsp.resp == fetch_pkg::RSP_DONE) && (f2e.instr != NOP_WORD);
            if (delivered) begin
                check_delivery();
                idx++;
                seen_exc = 1'b0;
                if (idx < rows.size()) begin
                    apply_event(rows[idx]);
                    model_pc = model_next_pc(rows[idx], model_pc);
                end
            end else if (f2e.instr !== NOP_WORD) begin
                // only nops between completed fetches
                report_mismatch(row_name(), "idle instr", NOP_WORD, f2e.instr);
            end
            // trap outputs settle on the inputs driven above
            #4;
            if (f2e.exc_start) begin
                seen_exc   = 1'b1;
                seen_cause = f2e.cause;
                seen_irq   = f2e.interrupt;
            end
        end
        if (idx < rows.size()) begin
            errors++;
            $display("timeout after %0d cycles, row %0d never got its instruction",
                     cycles, idx + 1);
        end
        $display("deliveries checked %0d, errors %0d, cycles %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_ctrl.sv
rtl/icache.sv
rtl/imem_rom.sv
rtl/fetch_top.sv
tb/tb_clkgen.sv
tb/fetch_assert.sv
tb/fetch_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fetch testbench with Verilator, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module fetch_tb -f project.f -o fetch_sim \
    && ./obj_dir/fetch_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation did not finish cleanly"; exit 1; }
exit 0
